// ==== verilog/obj_pkg.sv ====
`default_nettype none

// Object engine constants and shared types
package obj_pkg;

    localparam int obj_count    = 32;               // Objects in the table
    localparam int obj_bytes    = 4;                // Bytes per object record
    localparam int obj_aw       = 7;                // Attribute RAM address width
    localparam int obj_height   = 16;               // Lines per object
    localparam int obj_width    = 16;               // Pixels per object line
    localparam int credit_depth = 4;                // Draw queue slots = initial credits

    // Derived widths
    localparam int credit_cw = $clog2(credit_depth + 1);  // Holds 0..credit_depth
    localparam int queue_aw  = $clog2(credit_depth);      // Queue pointer
    localparam int beat_w    = $clog2(obj_bytes + 1);     // Address beats plus latency beat

    // Last scan address of the table
    localparam logic [obj_aw-1:0] obj_last_addr = obj_aw'(obj_count * obj_bytes - 1);

    // Record as the draw side sees it, top byte first
    typedef struct packed {
        logic [7:0] x;      // Byte 0
        logic [7:0] y;      // Byte 1
        logic [3:0] pal;    // Byte 2 upper nibble
        logic       hflip;
        logic       vflip;
        logic [1:0] spare;  // Unused attribute bits
        logic [7:0] code;   // Byte 3
    } obj_fields_t;

    // Same word, either as RAM bytes or as fields
    typedef union packed {
        logic [0:obj_bytes-1][7:0] bytes;  // Index is RAM byte offset, 0 lands on x
        obj_fields_t               f;
    } obj_rec_u;

    // Per-line scan sequence
    typedef enum logic [1:0] {
        scan_idle,
        scan_fetch,
        scan_wait_credit,   // Stalled at object boundary, no credit
        scan_drain          // Table done, draw still busy
    } scan_state_e;

endpackage

`default_nettype wire

// ==== verilog/obj_credit_if.sv ====
`default_nettype none

// Record path from fetch to draw with credit return
interface obj_credit_if import obj_pkg::*;;

    logic       rec_valid;      // One-cycle push, fetch side
    obj_rec_u   rec;
    logic [3:0] rec_row;        // Row inside object, vflip applied
    logic       credit_return;  // Pulse per queue pop, draw side
    logic       credit_avail;   // From the FSM credit counter
    logic       rec_pushed;

    // Draw never refuses a push, so every valid is a push
    assign rec_pushed = rec_valid;

    modport fetch_mp (
        output rec_valid, rec, rec_row,
        input  credit_avail
    );

    modport draw_mp (
        input  rec_valid, rec, rec_row,
        output credit_return
    );

    modport fsm_mp (
        input  rec_pushed, credit_return,
        output credit_avail
    );

endinterface

`default_nettype wire

// ==== verilog/obj_ram.sv ====
`default_nettype none

// Object attribute RAM, CPU writes only in vertical blank
module obj_ram import obj_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_cs,
    input  logic              cpu_wr_n,
    input  logic [obj_aw-1:0] cpu_addr,
    input  logic [7:0]        cpu_data,
    input  logic              lvbl,       // High during active video
    input  logic [obj_aw-1:0] scan_addr,
    output logic [7:0]        scan_q
);

    logic [7:0]        mem [obj_count*obj_bytes];
    logic [obj_aw-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic              wr_en;

    // CPU register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= cpu_cs && !cpu_wr_n && !lvbl;  // Active video writes die here
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_cs && !cpu_wr_n) begin
            wr_addr <= cpu_addr;
            wr_data <= cpu_data;
        end
    end

    // Storage, write one cycle after capture
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Scan port, one cycle read latency
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/obj_scan_counter.sv ====
`default_nettype none

// Object and byte index as one scan address
module obj_scan_counter import obj_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clear,      // Start of line
    input  logic              step,       // One byte read issued
    output logic [obj_aw-1:0] scan_addr,
    output logic              obj_last
);

    // Upper bits are the object, low two the byte
    logic [obj_aw-1:0] addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (step) begin
            addr <= addr + 1'b1;    // Wraps to object 0 after the last byte
        end
    end

    assign scan_addr = addr;

    // Final byte of final object
    assign obj_last = addr == obj_last_addr;

endmodule

`default_nettype wire

// ==== verilog/obj_scan_fsm.sv ====
`default_nettype none

// Per-line scan sequencer and credit counter
module obj_scan_fsm import obj_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic line_start,
    input  logic lvbl,
    input  logic obj_last,
    input  logic draw_idle,
    output logic clear,
    output logic step,
    output logic scan_busy,
    obj_credit_if.fsm_mp crd
);

    scan_state_e          state;
    logic [beat_w-1:0]    beat;         // 0..3 address beats, 4 read latency
    logic                 last_q;       // Final object in flight
    logic [credit_cw-1:0] credit_cnt;
    logic [credit_cw-1:0] credit_nxt;
    logic                 credit_ok;
    logic                 accept;

    assign accept = line_start && lvbl && state == scan_idle;
    assign clear  = accept;

    // Push and return may land together
    assign credit_nxt = credit_cnt - credit_cw'(crd.rec_pushed) + credit_cw'(crd.credit_return);
    assign credit_ok  = credit_nxt != '0;   // Previous object's push already counted

    assign crd.credit_avail = credit_cnt != '0;
    assign scan_busy        = state != scan_idle;

    // Beat 0 only steps with a credit in hand
    assign step = state == scan_fetch && beat != beat_w'(obj_bytes) &&
                  (beat != '0 || credit_ok);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= scan_idle;
            beat       <= '0;
            last_q     <= 1'b0;
            credit_cnt <= credit_cw'(credit_depth);
        end else begin
            credit_cnt <= credit_nxt;
            case (state)
                scan_idle: begin
                    if (accept) begin
                        state  <= scan_fetch;
                        beat   <= '0;
                        last_q <= 1'b0;
                    end
                end
                scan_fetch: begin
                    if (beat == '0 && !credit_ok) begin
                        state <= scan_wait_credit;   // Back-pressure point
                    end else if (beat == beat_w'(obj_bytes)) begin
                        beat <= '0;
                        if (last_q) state <= scan_drain;
                    end else begin
                        beat <= beat + 1'b1;
                        if (beat == beat_w'(obj_bytes - 1)) last_q <= obj_last;
                    end
                end
                scan_wait_credit: begin
                    if (credit_ok) state <= scan_fetch;
                end
                scan_drain: begin
                    // Last record may still be landing
                    if (draw_idle && !crd.rec_pushed) state <= scan_idle;
                end
                default: state <= scan_idle;
            endcase
        end
    end

    a_credit_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        credit_cnt <= credit_cw'(credit_depth) && (crd.rec_pushed -> credit_cnt != '0)
    ) else $error("credit count out of range");

    // Stall only at an object boundary with every credit out
    a_stall_no_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == scan_wait_credit |-> beat == '0 && credit_cnt == '0
    ) else $error("scan stalled with a credit in hand");

endmodule

`default_nettype wire

// ==== verilog/obj_fetch.sv ====
`default_nettype none

// Record assembly and line hit test
module obj_fetch import obj_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              line_start,   // Accepted line start only
    input  logic [7:0]        line,
    input  logic [obj_aw-1:0] scan_addr,
    input  logic [7:0]        scan_q,
    input  logic              step,
    obj_credit_if.fetch_mp    crd
);

    logic [7:0] line_q;
    logic [1:0] off_q;      // Byte offset aligned with scan_q
    logic       step_q;     // scan_q holds a requested byte
    logic       full;       // Record complete this cycle
    obj_rec_u   rec_q;
    logic [7:0] row8;
    logic       hit;

    // Read latency alignment
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_q <= 1'b0;
            off_q  <= '0;
            full   <= 1'b0;
        end else begin
            step_q <= step;
            off_q  <= scan_addr[1:0];
            full   <= step_q && off_q == 2'(obj_bytes - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            line_q <= line;
        end
        if (step_q) begin
            rec_q.bytes[off_q] <= scan_q;   // Byte view fill
        end
    end

    // Row inside object, wraps so objects above line 0 still hit
    assign row8 = line_q - rec_q.f.y;
    assign hit  = row8 < 8'(obj_height);

    // Next object's first byte arrives a cycle later, rec_q stable here
    assign crd.rec_valid = full && hit;
    assign crd.rec       = rec_q;
    assign crd.rec_row   = row8[3:0] ^ {4{rec_q.f.vflip}};  // vflip mirrors the row

    // Scan only reaches a push with a credit reserved
    a_push_has_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        crd.rec_valid |-> crd.credit_avail
    ) else $error("record pushed without credit");

endmodule

`default_nettype wire

// ==== verilog/obj_draw.sv ====
`default_nettype none

// Record queue and 16-pixel write sequencer
module obj_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    obj_credit_if.draw_mp crd,
    output logic        pix_we,
    output logic [7:0]  pix_x,
    output logic [11:0] pix_data,
    output logic        draw_idle
);

    obj_rec_u             q_rec [credit_depth];
    logic [3:0]           q_row [credit_depth];
    logic [queue_aw-1:0]  wr_ptr;
    logic [queue_aw-1:0]  rd_ptr;
    logic [credit_cw-1:0] q_count;
    obj_rec_u             cur_rec;  // Object being drawn
    logic [3:0]           cur_row;
    logic [3:0]           col;
    logic                 active;
    logic                 pop;

    // Pop on the last column too, so records run back to back
    assign pop = q_count != '0 && (!active || col == 4'(obj_width - 1));

    assign crd.credit_return = pop;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
            active  <= 1'b0;
            col     <= '0;
        end else begin
            if (crd.rec_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)           rd_ptr <= rd_ptr + 1'b1;
            q_count <= q_count + credit_cw'(crd.rec_valid) - credit_cw'(pop);
            if (pop) begin
                active <= 1'b1;
                col    <= '0;
            end else if (active) begin
                col <= col + 1'b1;
                if (col == 4'(obj_width - 1)) active <= 1'b0;
            end
        end
    end

    // Queue payload
    always_ff @(posedge clk) begin
        if (crd.rec_valid) begin
            q_rec[wr_ptr] <= crd.rec;
            q_row[wr_ptr] <= crd.rec_row;
        end
        if (pop) begin
            cur_rec <= q_rec[rd_ptr];
            cur_row <= q_row[rd_ptr];
        end
    end

    // Pixel data has no per-column content, so hflip changes nothing written
    assign pix_we    = active;
    assign pix_x     = cur_rec.f.x + {4'd0, col};   // Wraps past 255
    assign pix_data  = {cur_rec.f.pal, cur_rec.f.code[3:0], cur_row};
    assign draw_idle = !active && q_count == '0;

    a_queue_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        crd.rec_valid |-> q_count < credit_cw'(credit_depth)
    ) else $error("draw queue overflow");

endmodule

`default_nettype wire

// ==== verilog/obj_engine.sv ====
`default_nettype none

// Object engine top
module obj_engine import obj_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_cs,
    input  logic              cpu_wr_n,
    input  logic [obj_aw-1:0] cpu_addr,
    input  logic [7:0]        cpu_data,
    input  logic              lvbl,
    input  logic              line_start,
    input  logic [7:0]        line,
    output logic              pix_we,
    output logic [7:0]        pix_x,
    output logic [11:0]       pix_data,
    output logic              scan_busy
);

    logic [obj_aw-1:0] scan_addr;
    logic [7:0]        scan_q;
    logic              clear;       // Accepted line start
    logic              step;
    logic              obj_last;
    logic              draw_idle;

    obj_credit_if crd ();

    obj_ram u_obj_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_cs    (cpu_cs),
        .cpu_wr_n  (cpu_wr_n),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .lvbl      (lvbl),
        .scan_addr (scan_addr),
        .scan_q    (scan_q)
    );

    obj_scan_counter u_obj_scan_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .step      (step),
        .scan_addr (scan_addr),
        .obj_last  (obj_last)
    );

    obj_scan_fsm u_obj_scan_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_start (line_start),
        .lvbl       (lvbl),
        .obj_last   (obj_last),
        .draw_idle  (draw_idle),
        .clear      (clear),
        .step       (step),
        .scan_busy  (scan_busy),
        .crd        (crd)
    );

    // Fetch latches the line only when the FSM takes it
    obj_fetch u_obj_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_start (clear),
        .line       (line),
        .scan_addr  (scan_addr),
        .scan_q     (scan_q),
        .step       (step),
        .crd        (crd)
    );

    obj_draw u_obj_draw (
        .clk       (clk),
        .arst_n    (arst_n),
        .crd       (crd),
        .pix_we    (pix_we),
        .pix_x     (pix_x),
        .pix_data  (pix_data),
        .draw_idle (draw_idle)
    );

    // Pushes only come out of an active scan
    a_push_in_scan: assert property (
        @(posedge clk) disable iff (!arst_n)
        crd.rec_valid |-> u_obj_scan_fsm.state inside {scan_fetch, scan_drain}
    ) else $error("record pushed outside a scan");

    // Line end leaves draw empty and all credits home
    a_end_clean: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(scan_busy) |-> draw_idle &&
                             u_obj_scan_fsm.credit_cnt == credit_cw'(credit_depth)
    ) else $error("scan ended with draw busy or credits out");

endmodule

`default_nettype wire

// ==== tb/obj_engine_tb.sv ====
`default_nettype none

// Self-checking testbench for obj_engine, driven by tb/obj_testdata.txt
module obj_engine_tb import obj_pkg::*; ();

    logic              clk;
    logic              arst_n;
    logic              cpu_cs;
    logic              cpu_wr_n;
    logic [obj_aw-1:0] cpu_addr;
    logic [7:0]        cpu_data;
    logic              lvbl;
    logic              line_start;
    logic [7:0]        line;
    logic              pix_we;
    logic [7:0]        pix_x;
    logic [11:0]       pix_data;
    logic              scan_busy;

    // Parsed data file, one entry per record
    byte              rk [$];            // Record letter
    logic [31:0]      ra [$];
    logic [31:0]      rb [$];
    logic [31:0]      rc [$];
    logic [31:0]      rd [$];
    logic [31:0]      re [$];
    logic [8*24-1:0]  rn [$];            // Test name of L records

    logic [7:0]       shadow [obj_count*obj_bytes];  // Table as vblank writes leave it
    logic [7:0]       rule_x [$];        // Hits worked out from the table
    logic [11:0]      rule_d [$];
    logic [7:0]       file_x [$];        // Hits listed in the file
    logic [11:0]      file_d [$];
    logic [7:0]       exp_x [$];         // Pixel writes still to come
    logic [11:0]      exp_d [$];
    logic [8*24-1:0]  cur_name;
    logic [7:0]       mon_x;
    logic [11:0]      mon_d;
    int               lines = 0;
    int               writes = 0;
    int               limit = 0;         // Watchdog budget in cycles
    int               i;

    obj_engine u_obj_engine (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_cs     (cpu_cs),
        .cpu_wr_n   (cpu_wr_n),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .lvbl       (lvbl),
        .line_start (line_start),
        .line       (line),
        .pix_we     (pix_we),
        .pix_x      (pix_x),
        .pix_data   (pix_data),
        .scan_busy  (scan_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s expected %0h actual %0h", what, expected, actual);
            fail_run("value check failed");
        end
    endtask

    // Inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_data_file();
        int              fd;
        int              got;
        int              need;
        byte             kind;
        logic [8*200-1:0] skip;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        logic [31:0]     e;
        logic [8*24-1:0] nm;
        fd = $fopen("tb/obj_testdata.txt", "r");
        if (fd == 0) fail_run("cannot open tb/obj_testdata.txt");
        while (!$feof(fd)) begin
            got = $fscanf(fd, " %c", kind);
            if (got == 1 && kind == "#") begin
                got = $fgets(skip, fd);              // Comment line
            end else if (got == 1) begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                e = 0;
                nm = '0;
                case (kind)
                    "W": begin
                        need = 5;
                        got = $fscanf(fd, "%h %h %d %d %h", a, b, c, d, e);
                        writes += d;
                    end
                    "L": begin
                        need = 2;
                        got = $fscanf(fd, "%h %s", a, nm);
                        lines++;
                    end
                    "E": begin
                        need = 4;
                        got = $fscanf(fd, "%h %h %d %h", a, b, c, d);
                    end
                    default: fail_run("data file holds an unknown record type");
                endcase
                if (got != need) fail_run("data file holds a malformed record");
                rk.push_back(kind);
                ra.push_back(a);
                rb.push_back(b);
                rc.push_back(c);
                rd.push_back(d);
                re.push_back(e);
                rn.push_back(nm);
            end
        end
        $fclose(fd);
    endtask

    // W: count writes, address steps one object, data steps by e
    task automatic write_block(input int r);
        int         k;
        logic [6:0] wa;
        logic [7:0] data;
        data = rb[r][7:0];
        for (k = 0; k < rd[r]; k++) begin
            wa       = 7'(ra[r] + obj_bytes * k);
            cpu_cs   = 1'b1;
            cpu_wr_n = 1'b0;
            cpu_addr = wa;
            cpu_data = data;
            lvbl     = rc[r][0];
            if (!rc[r][0]) shadow[wa] = data;    // Only blank writes stick
            data = data + re[r][7:0];
            next_cycle();
        end
        cpu_cs   = 1'b0;
        cpu_wr_n = 1'b1;
        next_cycle();                            // Last write lands
        next_cycle();
    endtask

    // Rule model vs. E records, then queue the pixel writes
    task automatic expect_line(input int r);
        int         k;
        int         j;
        int         n;
        logic [7:0] row;
        logic [7:0] attr;
        logic [3:0] r4;
        logic [7:0] fx;
        rule_x.delete();
        rule_d.delete();
        file_x.delete();
        file_d.delete();
        for (k = 0; k < obj_count; k++) begin
            row  = ra[r][7:0] - shadow[obj_bytes*k+1];   // Line minus y, mod 256
            attr = shadow[obj_bytes*k+2];
            if (row < obj_height) begin
                r4 = attr[2] ? 4'd15 - row[3:0] : row[3:0];  // vflip
                rule_x.push_back(shadow[obj_bytes*k]);
                rule_d.push_back({attr[7:4], shadow[obj_bytes*k+3][3:0], r4});
            end
        end
        j = r + 1;
        while (j < rk.size() && rk[j] == "E") begin
            fx = ra[j][7:0];
            for (n = 0; n < rc[j]; n++) begin
                file_x.push_back(fx);
                file_d.push_back(rb[j][11:0]);
                fx = fx + rd[j][7:0];
            end
            j++;
        end
        if (rule_x.size() != file_x.size())
            fail_run($sformatf("data file lists the wrong object count for %0s", cur_name));
        for (k = 0; k < rule_x.size(); k++) begin
            if (rule_x[k] !== file_x[k] || rule_d[k] !== file_d[k])
                fail_run($sformatf("data file entry %0d of %0s disagrees with the table",
                                   k, cur_name));
        end
        for (k = 0; k < file_x.size(); k++) begin
            for (n = 0; n < obj_width; n++) begin
                exp_x.push_back(8'(file_x[k] + n));  // x wraps past 255
                exp_d.push_back(file_d[k]);
            end
        end
    endtask

    task automatic run_line(input int r);
        cur_name = rn[r];
        expect_line(r);
        lvbl       = 1'b1;
        line       = ra[r][7:0];
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
        check($sformatf("%0s scan_busy rise", cur_name), 1, scan_busy);
        next_cycle();
        next_cycle();
        line       = ~ra[r][7:0];                // Busy, so this start is dropped
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
        while (scan_busy) next_cycle();
        check($sformatf("%0s writes left", cur_name), 0, exp_x.size());
        next_cycle();
    endtask

    // Pixel writes in order against the expected queue
    always @(negedge clk) begin
        if (arst_n && pix_we) begin
            if (exp_x.size() == 0) begin
                fail_run($sformatf("pixel write with nothing expected in %0s", cur_name));
            end else begin
                mon_x = exp_x.pop_front();
                mon_d = exp_d.pop_front();
                check($sformatf("%0s pix_x", cur_name), mon_x, pix_x);
                check($sformatf("%0s pix_data", cur_name), mon_d, pix_data);
            end
        end
    end

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        fail_run($sformatf("watchdog expired after %0d cycles", limit));
    end

    initial begin
        arst_n     = 1'b0;
        cpu_cs     = 1'b0;
        cpu_wr_n   = 1'b1;
        cpu_addr   = '0;
        cpu_data   = '0;
        lvbl       = 1'b0;
        line_start = 1'b0;
        line       = '0;
        cur_name   = "reset";
        for (i = 0; i < obj_count * obj_bytes; i++) shadow[i] = 8'h00;
        read_data_file();
        limit = 200 * lines + 10 * writes + 20;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        for (i = 0; i < rk.size(); i++) begin
            case (rk[i])
                "W": write_block(i);
                "L": run_line(i);
                default: ;                       // E belongs to the L before it
            endcase
        end
        next_cycle();
        if (exp_x.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("expected pixel writes never appeared");
        end
    end

endmodule

`default_nettype wire

// ==== tb/obj_testdata.txt ====
# W addr(hex) data(hex) lvbl count step(hex): count writes, addr +4 each, data +step each
# L line(hex) name: line request;  E x(hex) pixdata(hex) count xstep(hex): 16 writes per object
# Park every object off the tested lines
W 00 00 0 32 00
W 01 e0 0 32 00
W 02 00 0 32 00
W 03 00 0 32 00
# Objects 0-3, mixed flips, object 0 one line short
W 00 10 0 4 30
W 01 28 0 4 01
W 02 50 0 4 04
W 03 a3 0 4 01
L 38 basic
E 40 540 1 00
E 70 55e 1 00
E a0 562 1 00
L 2b basic_top
E 10 533 1 00
E 40 54d 1 00
E 70 551 1 00
E a0 56f 1 00
# Active video writes must be lost
W 00 99 1 4 00
W 01 38 1 4 00
L 38 dropped
E 40 540 1 00
E 70 55e 1 00
E a0 562 1 00
# Object 4 near both wrap points
W 10 f8 0 1 00
W 11 f8 0 1 00
W 12 30 0 1 00
W 13 09 0 1 00
L 03 wrap
E f8 39b 1 00
L 08 wrap_edge
# Every object on one line
W 00 00 0 32 08
W 01 60 0 32 00
W 02 a1 0 32 00
W 03 c5 0 32 00
L 65 backpressure
E 00 a55 32 08

// ==== verilog.f ====
verilog/obj_pkg.sv
verilog/obj_credit_if.sv
verilog/obj_ram.sv
verilog/obj_scan_counter.sv
verilog/obj_scan_fsm.sv
verilog/obj_fetch.sv
verilog/obj_draw.sv
verilog/obj_engine.sv
tb/obj_engine_tb.sv

// ==== Makefile ====
# Verilator build and run of the object engine testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build obj_engine_tb with Verilator and run it"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module obj_engine_tb -o obj_engine_tb
	./obj_dir/obj_engine_tb

clean:
	rm -rf obj_dir
